//--- rtl/fetch_pkg.sv
package fetch_pkg;

    localparam int xlen = 32;

    // First fetch address after reset
    localparam logic [xlen-1:0] reset_pc = 32'h1c00_0000;

    localparam logic [5:0] op_b  = 6'b010100;
    localparam logic [5:0] op_bl = 6'b010101;

    // Decode to fetch branch bundle
    typedef struct packed {
        logic            br_stall;
        logic            br_taken;
        logic [xlen-1:0] br_target;
    } br_bus_t;

    typedef struct packed {
        logic            adef;
        logic [xlen-1:0] inst;
        logic [xlen-1:0] pc;
    } fs_to_ds_t;

    typedef struct packed {
        logic [xlen-1:0] pc;
        logic [xlen-1:0] inst;
        logic            adef;
        logic            is_branch;
    } ds_out_t;

    // Pending redirect cause, in priority order
    typedef enum logic [1:0] {
        redir_none,
        redir_exception,
        redir_ertn,
        redir_branch
    } redirect_e;

    function automatic logic is_b_op(input logic [xlen-1:0] inst);
        return (inst[31:26] == op_b) || (inst[31:26] == op_bl);
    endfunction

    // Word 15 of every 32-word block is a B with offs26 = 4, the rest carry their address
    function automatic logic [xlen-1:0] inst_image(input logic [xlen-1:0] a);
        if (a[6:2] == 5'd15) begin
            return {op_b, 16'd4, 10'd0};
        end
        return {6'b000000, a[27:2]};
    endfunction

endpackage

//--- rtl/fetch_stage.sv
`timescale 1ns/1ps

module fetch_stage import fetch_pkg::*; #(
    parameter int CANCEL_MAX = 7
) (
    input  logic        clk,
    input  logic        resetn,
    // Instruction memory
    output logic        req,
    output logic [31:0] addr,
    input  logic        addr_ok,
    input  logic        data_ok,
    input  logic [31:0] rdata,
    // Decode stage
    input  logic        ds_allowin,
    input  br_bus_t     br,
    output logic        fs_to_ds_valid,
    output fs_to_ds_t   fs_to_ds,
    // Redirects from later stages
    input  logic        wb_ex,
    input  logic        ertn_flush,
    input  logic [31:0] ex_entry,
    input  logic [31:0] ertn_entry
);

    localparam int cnt_w = $clog2(CANCEL_MAX + 1);

    logic             pf_en;
    logic             fs_valid;
    logic [31:0]      fs_pc;
    logic [31:0]      seq_pc;
    logic [31:0]      nextpc;

    redirect_e        now_cause;
    logic [31:0]      now_target;
    logic             redirect_now;
    redirect_e        held_cause;
    logic [31:0]      held_target;

    logic [cnt_w-1:0] cancel_cnt;
    logic             cancel_pending;
    logic             cancel_inc;
    logic             cancel_dec;

    logic             resp_ok;
    logic             fs_ready_go;
    logic             fs_leave;
    logic             fs_free;
    logic             accept;

    logic [31:0]      inst_buf;
    logic             inst_buf_valid;
    logic [31:0]      fs_inst;

    // Same-cycle redirect with exception over ertn over branch
    always_comb begin
        now_cause  = redir_none;
        now_target = br.br_target;
        if (wb_ex) begin
            now_cause  = redir_exception;
            now_target = ex_entry;
        end else if (ertn_flush) begin
            now_cause  = redir_ertn;
            now_target = ertn_entry;
        end else if (br.br_taken) begin
            now_cause  = redir_branch;
        end
    end

    assign redirect_now = (now_cause != redir_none);

    assign seq_pc = fs_pc + 32'd4;
    assign nextpc = redirect_now               ? now_target  :
                    (held_cause != redir_none) ? held_target : seq_pc;

    // Held off for the first cycle out of reset
    always_ff @(posedge clk) begin
        if (!resetn) begin
            pf_en <= 1'b0;
        end else begin
            pf_en <= 1'b1;
        end
    end

    assign cancel_pending = (cancel_cnt != '0);
    assign resp_ok        = data_ok & ~cancel_pending;  // Response of the live request
    assign fs_ready_go    = inst_buf_valid | resp_ok;

    assign fs_to_ds_valid = fs_valid & fs_ready_go & ~redirect_now;
    assign fs_leave       = fs_to_ds_valid & ds_allowin;

    // A redirect throws the current word away and frees the slot
    assign fs_free = ~fs_valid | fs_leave | redirect_now;

    assign req    = pf_en & fs_free & ~br.br_stall;
    assign addr   = nextpc;
    assign accept = req & addr_ok;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            fs_valid <= 1'b0;
        end else if (fs_free) begin
            fs_valid <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            fs_pc <= reset_pc - 32'd4;
        end else if (accept) begin
            fs_pc <= nextpc;
        end
    end

    // Redirect is remembered until its address is accepted
    always_ff @(posedge clk) begin
        if (!resetn) begin
            held_cause <= redir_none;
        end else if (redirect_now && !accept) begin
            held_cause <= now_cause;
        end else if (accept) begin
            held_cause <= redir_none;
        end
    end

    always_ff @(posedge clk) begin
        if (redirect_now && !accept) begin
            held_target <= now_target;
        end
    end

    // Responses still owed to requests killed by a redirect
    assign cancel_inc = redirect_now & fs_valid & ~fs_ready_go;
    assign cancel_dec = cancel_pending & data_ok;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            cancel_cnt <= '0;
        end else begin
            case ({cancel_inc, cancel_dec})
                2'b10:   cancel_cnt <= cancel_cnt + 1'b1;
                2'b01:   cancel_cnt <= cancel_cnt - 1'b1;
                default: cancel_cnt <= cancel_cnt;
            endcase
        end
    end

    // One word kept while decode is blocked
    always_ff @(posedge clk) begin
        if (!resetn) begin
            inst_buf_valid <= 1'b0;
        end else if (redirect_now || fs_leave) begin
            inst_buf_valid <= 1'b0;
        end else if (fs_valid && resp_ok && !inst_buf_valid) begin
            inst_buf_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (resp_ok && !inst_buf_valid) begin
            inst_buf <= rdata;
        end
    end

    assign fs_inst = inst_buf_valid ? inst_buf : rdata;

    assign fs_to_ds = '{
        adef: |fs_pc[1:0],  // Misaligned fetch address
        inst: fs_inst,
        pc:   fs_pc
    };

    a_cancel_bound: assert property (
        @(posedge clk) disable iff (!resetn)
        (cancel_inc && !cancel_dec) |-> cancel_cnt < CANCEL_MAX
    );

    a_no_req_in_reset: assert property (
        @(posedge clk) !resetn |=> !req
    );

endmodule

//--- rtl/inst_mem.sv
`timescale 1ns/1ps

module inst_mem import fetch_pkg::*; #(
    parameter int RESP_LAT = 2
) (
    input  logic        clk,
    input  logic        resetn,
    input  logic        req,
    input  logic [31:0] addr,
    output logic        addr_ok,
    output logic        data_ok,
    output logic [31:0] rdata
);

    localparam logic [7:0] lfsr_seed = 8'ha5;

    logic [7:0]          lfsr;
    logic                lfsr_fb;
    logic                accept;

    logic [RESP_LAT-1:0] vld_pipe;
    logic [31:0]         addr_pipe [RESP_LAT];

    // x^8 + x^6 + x^5 + x^4 + 1
    assign lfsr_fb = lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3];

    always_ff @(posedge clk) begin
        if (!resetn) begin
            lfsr <= lfsr_seed;
        end else begin
            lfsr <= {lfsr[6:0], lfsr_fb};
        end
    end

    // Roughly one cycle in four refuses a request
    assign addr_ok = |lfsr[1:0];
    assign accept  = req & addr_ok;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            vld_pipe <= '0;
        end else begin
            vld_pipe[0] <= accept;
            for (int i = 1; i < RESP_LAT; i++) begin
                vld_pipe[i] <= vld_pipe[i-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        addr_pipe[0] <= addr;
        for (int i = 1; i < RESP_LAT; i++) begin
            addr_pipe[i] <= addr_pipe[i-1];
        end
    end

    // Last stage of the pipe is the response, in acceptance order
    assign data_ok = vld_pipe[RESP_LAT-1];
    assign rdata   = inst_image(addr_pipe[RESP_LAT-1]);

    a_resp_after_accept: assert property (
        @(posedge clk) disable iff (!resetn)
        data_ok |-> $past(req && addr_ok, RESP_LAT)
    );

endmodule

//--- rtl/decode_stage.sv
`timescale 1ns/1ps

module decode_stage import fetch_pkg::*; (
    input  logic      clk,
    input  logic      resetn,
    // Fetch stage
    input  logic      fs_to_ds_valid,
    input  fs_to_ds_t fs_to_ds,
    output logic      ds_allowin,
    output br_bus_t   br,
    // Downstream
    output logic      out_valid,
    output ds_out_t   out_bus,
    input  logic      out_ready,
    // Flush
    input  logic      wb_ex,
    input  logic      ertn_flush
);

    logic        ds_valid;
    fs_to_ds_t   ds_r;
    logic        flush;
    logic        ds_go;
    logic        is_branch;
    logic [25:0] offs26;
    logic [31:0] br_offs;

    assign flush = wb_ex | ertn_flush;

    // An instruction being flushed is never handed on
    assign out_valid  = ds_valid & ~flush;
    assign ds_go      = out_valid & out_ready;
    assign ds_allowin = ~ds_valid | ds_go;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            ds_valid <= 1'b0;
        end else if (flush) begin
            ds_valid <= 1'b0;
        end else if (ds_allowin) begin
            ds_valid <= fs_to_ds_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (fs_to_ds_valid && ds_allowin) begin
            ds_r <= fs_to_ds;
        end
    end

    // B and BL only, a fetch fault is not decoded
    assign is_branch = is_b_op(ds_r.inst) & ~ds_r.adef;

    assign offs26  = {ds_r.inst[9:0], ds_r.inst[25:10]};
    assign br_offs = {{4{offs26[25]}}, offs26, 2'b00};

    // Taken on the way out, stall while waiting
    assign br = '{
        br_stall:  ds_valid & is_branch & ~ds_go & ~flush,
        br_taken:  ds_go & is_branch,
        br_target: ds_r.pc + br_offs
    };

    assign out_bus = '{
        pc:        ds_r.pc,
        inst:      ds_r.inst,
        adef:      ds_r.adef,
        is_branch: is_branch
    };

    a_br_exclusive: assert property (
        @(posedge clk) disable iff (!resetn) !(br.br_taken && br.br_stall)
    );

endmodule

//--- rtl/fetch_top.sv
`timescale 1ns/1ps

module fetch_top import fetch_pkg::*; #(
    parameter int RESP_LAT   = 2,
    parameter int CANCEL_MAX = 7
) (
    input  logic        clk,
    input  logic        resetn,
    input  logic        out_ready,
    input  logic        wb_ex,
    input  logic        ertn_flush,
    input  logic [31:0] ex_entry,
    input  logic [31:0] ertn_entry,
    output logic        out_valid,
    output ds_out_t     out_bus
);

    // Memory bus
    logic        req;
    logic [31:0] addr;
    logic        addr_ok;
    logic        data_ok;
    logic [31:0] rdata;

    // Fetch to decode
    logic        fs_to_ds_valid;
    fs_to_ds_t   fs_to_ds;
    logic        ds_allowin;
    br_bus_t     br;

    fetch_stage #(
        .CANCEL_MAX (CANCEL_MAX)
    ) u_fetch (
        .clk            (clk),
        .resetn         (resetn),
        .req            (req),
        .addr           (addr),
        .addr_ok        (addr_ok),
        .data_ok        (data_ok),
        .rdata          (rdata),
        .ds_allowin     (ds_allowin),
        .br             (br),
        .fs_to_ds_valid (fs_to_ds_valid),
        .fs_to_ds       (fs_to_ds),
        .wb_ex          (wb_ex),
        .ertn_flush     (ertn_flush),
        .ex_entry       (ex_entry),
        .ertn_entry     (ertn_entry)
    );

    inst_mem #(
        .RESP_LAT (RESP_LAT)
    ) u_imem (
        .clk     (clk),
        .resetn  (resetn),
        .req     (req),
        .addr    (addr),
        .addr_ok (addr_ok),
        .data_ok (data_ok),
        .rdata   (rdata)
    );

    decode_stage u_decode (
        .clk            (clk),
        .resetn         (resetn),
        .fs_to_ds_valid (fs_to_ds_valid),
        .fs_to_ds       (fs_to_ds),
        .ds_allowin     (ds_allowin),
        .br             (br),
        .out_valid      (out_valid),
        .out_bus        (out_bus),
        .out_ready      (out_ready),
        .wb_ex          (wb_ex),
        .ertn_flush     (ertn_flush)
    );

endmodule

//--- tb/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,
    output logic resetn
);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;  // 8 ns period
    end

    // Held for eight rising edges, released just after the last one
    initial begin
        resetn = 1'b0;
        repeat (8) @(posedge clk);
        #1 resetn = 1'b1;
    end

endmodule

//--- tb/fetch_tb.sv
`timescale 1ns/1ps

module fetch_tb import fetch_pkg::*; ();

    localparam int step_limit = 60;  // Cycles allowed per expected output

    logic        clk;
    logic        resetn;
    logic        out_ready;
    logic        wb_ex;
    logic        ertn_flush;
    logic [31:0] ex_entry;
    logic [31:0] ertn_entry;
    logic        out_valid;
    ds_out_t     out_bus;

    logic [31:0] exp_pc;
    redirect_e   exp_cause;
    logic [31:0] exp_inst;
    logic        exp_adef;
    logic        exp_branch;
    ds_out_t     prev_bus;
    logic        transfer;
    logic        held;

    int errors = 0;
    int timeouts = 0;
    int xfer_count = 0;
    int reset_cycles = 0;
    int branches_seen = 0;
    int adef_seen = 0;
    int entries_seen = 0;
    int ready_hold = 0;

    tb_clock_gen clock_gen (
        .clk    (clk),
        .resetn (resetn)
    );

    fetch_top #(
        .RESP_LAT   (2),
        .CANCEL_MAX (7)
    ) uut (
        .clk        (clk),
        .resetn     (resetn),
        .out_ready  (out_ready),
        .wb_ex      (wb_ex),
        .ertn_flush (ertn_flush),
        .ex_entry   (ex_entry),
        .ertn_entry (ertn_entry),
        .out_valid  (out_valid),
        .out_bus    (out_bus)
    );

    assign exp_inst   = inst_image(exp_pc);
    assign exp_adef   = |exp_pc[1:0];
    assign exp_branch = is_b_op(exp_inst) & ~exp_adef;
    assign transfer   = out_valid & out_ready;
    assign held       = out_valid & ~out_ready;

    // A redirect wins over an output in the same cycle
    always @(posedge clk) begin
        prev_bus <= out_bus;
        if (!resetn) begin
            reset_cycles <= reset_cycles + 1;
            exp_pc       <= reset_pc;
            exp_cause    <= redir_none;
        end else if (wb_ex) begin
            exp_pc    <= ex_entry;
            exp_cause <= redir_exception;
        end else if (ertn_flush) begin
            exp_pc    <= ertn_entry;
            exp_cause <= redir_ertn;
        end else if (transfer) begin
            xfer_count    <= xfer_count + 1;
            branches_seen <= branches_seen + int'(exp_branch);
            adef_seen     <= adef_seen + int'(exp_adef);
            if (exp_cause == redir_exception || exp_cause == redir_ertn) begin
                entries_seen <= entries_seen + 1;
            end
            exp_pc    <= exp_branch ? exp_pc + 32'd16 : exp_pc + 32'd4;  // Image B jumps 4 words
            exp_cause <= exp_branch ? redir_branch : redir_none;
        end
    end

    task automatic report_value(input string name, input logic [65:0] got,
                                input logic [65:0] expected, input redirect_e cause);
        errors++;
        $display("** Error at %0t ns: %s = 0x%0h, expected 0x%0h (last redirect %s)",
                 $time, name, got, expected, cause.name());
    endtask

    task automatic report_text(input string msg);
        errors++;
        $display("Error at %0t ns: %s", $time, msg);
    endtask

    a_reset_quiet: assert property (
        @(posedge clk) (!resetn && reset_cycles != 0) |-> !out_valid
    ) else report_text("out_valid was high during reset");

    a_out_pc: assert property (
        @(posedge clk) disable iff (!resetn) transfer |-> out_bus.pc == exp_pc
    ) else report_value("out_bus.pc", $sampled(out_bus.pc), $sampled(exp_pc), $sampled(exp_cause));

    a_out_inst: assert property (
        @(posedge clk) disable iff (!resetn) transfer |-> out_bus.inst == exp_inst
    ) else report_value("out_bus.inst", $sampled(out_bus.inst), $sampled(exp_inst),
                        $sampled(exp_cause));

    a_out_adef: assert property (
        @(posedge clk) disable iff (!resetn) transfer |-> out_bus.adef == exp_adef
    ) else report_value("out_bus.adef", $sampled(out_bus.adef), $sampled(exp_adef),
                        $sampled(exp_cause));

    a_out_branch: assert property (
        @(posedge clk) disable iff (!resetn) transfer |-> out_bus.is_branch == exp_branch
    ) else report_value("out_bus.is_branch", $sampled(out_bus.is_branch), $sampled(exp_branch),
                        $sampled(exp_cause));

    // Stalled output keeps its contents and only a flush may drop it
    a_hold_bus: assert property (
        @(posedge clk) disable iff (!resetn) held |=> out_bus == prev_bus
    ) else report_value("out_bus", $sampled(out_bus), $sampled(prev_bus), $sampled(exp_cause));

    a_hold_valid: assert property (
        @(posedge clk) disable iff (!resetn) held |=> out_valid || wb_ex || ertn_flush
    ) else report_text("out_valid dropped while the output was stalled");

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic drive_ready(input bit random_ready);
        if (!random_ready) begin
            out_ready = 1'b1;
        end else if (ready_hold > 0) begin
            ready_hold--;
            out_ready = 1'b0;
        end else if ($urandom % 16 == 0) begin
            ready_hold = $urandom % 12;  // Long stall
            out_ready  = 1'b0;
        end else begin
            out_ready = ($urandom % 4) != 0;
        end
    endtask

    task automatic wait_reset();
        int waited;
        waited = 0;
        while (!resetn && waited < 40) begin
            step();
            waited++;
        end
        if (!resetn) begin
            timeouts++;
            $display("Timeout: reset was never released");
        end
    endtask

    task automatic run_transfers(input int count, input bit random_ready);
        int target;
        int waited;
        target = xfer_count + count;
        waited = 0;
        if (timeouts != 0) return;
        while (xfer_count < target && waited < (count + 1) * step_limit) begin
            drive_ready(random_ready);
            step();
            waited++;
        end
        if (xfer_count < target) begin
            timeouts++;
            $display("Timeout: only %0d of %0d outputs arrived", count - (target - xfer_count),
                     count);
        end
    endtask

    task automatic pulse_redirect(input bit is_ertn, input logic [31:0] entry);
        if (is_ertn) begin
            ertn_entry = entry;
            ertn_flush = 1'b1;
        end else begin
            ex_entry = entry;
            wb_ex    = 1'b1;
        end
        step();
        wb_ex      = 1'b0;
        ertn_flush = 1'b0;
    endtask

    // Pulse lands in the cycle a branch would leave decode
    task automatic pulse_on_branch(input bit is_ertn, input logic [31:0] entry);
        int waited;
        waited = 0;
        if (timeouts != 0) return;
        out_ready = 1'b1;
        step();
        while (!(out_valid && out_bus.is_branch) && waited < 20 * step_limit) begin
            step();
            waited++;
        end
        if (out_valid && out_bus.is_branch) begin
            pulse_redirect(is_ertn, entry);
        end else begin
            timeouts++;
            $display("Timeout: no branch reached the decode output");
        end
    endtask

    function automatic logic [31:0] random_entry();
        return reset_pc + (($urandom % 2048) << 2);
    endfunction

    task automatic finish_run();
        assert (branches_seen > 0) else report_text("no branch reached the output");
        assert (adef_seen > 0) else report_text("no misaligned fetch reached the output");
        assert (entries_seen > 0) else report_text("no redirect entry reached the output");
        $display("Summary: %0d errors, %0d timeouts, %0d outputs, %0d branches",
                 errors, timeouts, xfer_count, branches_seen);
        if (errors == 0 && timeouts == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    endtask

    initial begin
        out_ready  = 1'b0;
        wb_ex      = 1'b0;
        ertn_flush = 1'b0;
        ex_entry   = '0;
        ertn_entry = '0;
        void'($urandom(34));
        wait_reset();

        run_transfers(48, 1'b0);   // Straight run through a few branches
        run_transfers(120, 1'b1);

        // Exceptions and returns at random points
        for (int i = 0; i < 12; i++) begin
            run_transfers($urandom % 6, 1'b1);
            pulse_redirect(i[0], random_entry());
            run_transfers(3, 1'b1);
        end

        pulse_on_branch(1'b0, random_entry());
        run_transfers(4, 1'b0);
        pulse_on_branch(1'b1, random_entry());
        run_transfers(4, 1'b0);

        pulse_redirect(1'b1, reset_pc + 32'h206);  // Misaligned return address
        run_transfers(6, 1'b1);
        pulse_redirect(1'b0, reset_pc + 32'h400);
        run_transfers(40, 1'b1);
        finish_run();
    end

endmodule

//--- fetch_top.f
rtl/fetch_pkg.sv
rtl/fetch_stage.sv
rtl/inst_mem.sv
rtl/decode_stage.sv
rtl/fetch_top.sv
tb/tb_clock_gen.sv
tb/fetch_tb.sv
